// File: all.f
rtl/aes_pkg.sv
rtl/aes_sbox.sv
rtl/aes_round.sv
rtl/aes_key_step.sv
rtl/aes_core.sv
rtl/reset_pulse_ext.sv
rtl/wb_aes_regs.sv
rtl/aes_soc_top.sv
verif/tb_aes_soc.sv

// File: rtl/aes_core.sv
// ========================================================================
// aes_core
// iterative AES-128 encryption at one round per clock and 10 cycle latency
// ========================================================================

module aes_core
  import aes_pkg::*;
(
  input  logic       clock_50,
  input  logic       rst_n,
  input  logic       start,       // ignored while busy
  input  aes_block_u plaintext,
  input  aes_block_u key,
  output logic       busy,
  output logic       done,        // one cycle pulse when ciphertext is valid
  output aes_block_u ciphertext
);

  aes_block_u state;
  aes_block_u round_key;   // key of the previous round
  aes_block_u next_state;
  aes_block_u next_key;    // key used by the round in flight
  round_cnt_t round_cnt;   // 1..10 while busy
  byte_t      rcon;
  logic       last;

  assign last = (round_cnt == AES_ROUNDS);

  aes_key_step key_step_i (
    .round_key (round_key),
    .rcon      (rcon),
    .next_key  (next_key)
  );

  aes_round round_i (
    .state      (state),
    .round_key  (next_key),
    .last       (last),
    .next_state (next_state)
  );

  // ======================================================================
  // control
  // ======================================================================
  always_ff @(posedge clock_50) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      done      <= 1'b0;
      round_cnt <= '0;
      rcon      <= '0;
    end else begin
      done <= 1'b0;
      if (!busy) begin
        if (start) begin
          busy      <= 1'b1;
          round_cnt <= 4'd1;
          rcon      <= 8'h01;   // rcon of round 1
        end
      end else if (last) begin
        busy      <= 1'b0;       // round 10 done here
        done      <= 1'b1;
        round_cnt <= '0;
      end else begin
        round_cnt <= round_cnt + 1'b1;
        rcon      <= xtime(rcon);  // 01 02 04 .. 1b 36
      end
    end
  end

  // ======================================================================
  // datapath
  // ======================================================================
  always_ff @(posedge clock_50) begin
    if (!rst_n) begin
      state      <= '0;
      round_key  <= '0;
      ciphertext <= '0;
    end else begin
      if (!busy && start) begin
        state     <= plaintext ^ key;  // initial AddRoundKey
        round_key <= key;
      end else if (busy) begin
        state     <= next_state;
        round_key <= next_key;
      end
      if (busy && last) ciphertext <= next_state;  // holds until next block
    end
  end

endmodule

// File: rtl/aes_key_step.sv
// ========================================================================
// aes_key_step
// AES-128 key expansion, derives the next round key from the current one
// ========================================================================

module aes_key_step
  import aes_pkg::*;
(
  input  aes_block_u round_key,
  input  byte_t      rcon,       // round constant of the new key
  output aes_block_u next_key
);

  byte_t [0:3] rot_b;  // RotWord of the last column
  byte_t [0:3] sub_b;  // SubWord of it
  word_t       tmp;

  assign rot_b = {round_key.w[3][23:0], round_key.w[3][31:24]};

  for (genvar i = 0; i < 4; i++) begin : g_sbox
    aes_sbox sbox_i (.in(rot_b[i]), .out(sub_b[i]));
  end

  assign tmp = sub_b ^ {rcon, 24'h000000};  // rcon only in the top byte

  // chained xor, each column feeds the next
  always_comb begin
    next_key.w[0] = round_key.w[0] ^ tmp;
    next_key.w[1] = round_key.w[1] ^ next_key.w[0];
    next_key.w[2] = round_key.w[2] ^ next_key.w[1];
    next_key.w[3] = round_key.w[3] ^ next_key.w[2];
  end

endmodule

// File: rtl/aes_pkg.sv
// ========================================================================
// aes_pkg
// shared types, register map and helpers for the AES-128 accelerator
// ========================================================================

package aes_pkg;

  typedef logic [31:0] word_t;  // one bus word
  typedef logic [7:0]  byte_t;  // one state byte

  // 128-bit block, byte 0 and column 0 sit in the top bits
  typedef union packed {
    byte_t [0:15] b;  // byte lanes for SubBytes and ShiftRows
    word_t [0:3]  w;  // columns for MixColumns and the bus
  } aes_block_u;

  typedef logic [3:0] reg_addr_t;   // wishbone word address
  typedef logic [3:0] round_cnt_t;  // round counter

  // register map
  localparam reg_addr_t REG_CTRL   = 4'd0;   // bit 0 starts a block
  localparam reg_addr_t REG_PT0    = 4'd1;
  localparam reg_addr_t REG_PT1    = 4'd2;
  localparam reg_addr_t REG_PT2    = 4'd3;
  localparam reg_addr_t REG_PT3    = 4'd4;
  localparam reg_addr_t REG_KEY0   = 4'd5;
  localparam reg_addr_t REG_KEY1   = 4'd6;
  localparam reg_addr_t REG_KEY2   = 4'd7;
  localparam reg_addr_t REG_KEY3   = 4'd8;
  localparam reg_addr_t REG_CT0    = 4'd9;
  localparam reg_addr_t REG_CT1    = 4'd10;
  localparam reg_addr_t REG_CT2    = 4'd11;
  localparam reg_addr_t REG_CT3    = 4'd12;
  localparam reg_addr_t REG_STATUS = 4'd13;  // bit 0 busy, bit 1 done

  localparam round_cnt_t AES_ROUNDS = 4'd10;  // aes-128

  // multiply by x in GF(2^8), poly x^8+x^4+x^3+x+1
  function automatic byte_t xtime(byte_t a);
    return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
  endfunction

endpackage

// File: rtl/aes_round.sv
// ========================================================================
// aes_round
// one combinational cipher round: SubBytes, ShiftRows, MixColumns
// (skipped in the final round) and AddRoundKey
// ========================================================================

module aes_round
  import aes_pkg::*;
(
  input  aes_block_u state,
  input  aes_block_u round_key,
  input  logic       last,       // final round, no MixColumns
  output aes_block_u next_state
);

  byte_t [0:15] sub_b;  // after SubBytes
  aes_block_u   shift;  // after ShiftRows
  aes_block_u   mix;    // after MixColumns

  // mix one column, doubling-and-xor form
  function automatic word_t mix_col(word_t col);
    byte_t a0, a1, a2, a3;
    byte_t t;
    a0 = col[31:24];
    a1 = col[23:16];
    a2 = col[15:8];
    a3 = col[7:0];
    t  = a0 ^ a1 ^ a2 ^ a3;
    return {a0 ^ t ^ xtime(a0 ^ a1),
            a1 ^ t ^ xtime(a1 ^ a2),
            a2 ^ t ^ xtime(a2 ^ a3),
            a3 ^ t ^ xtime(a3 ^ a0)};
  endfunction

  // sixteen parallel lookups
  for (genvar i = 0; i < 16; i++) begin : g_sbox
    aes_sbox sbox_i (.in(state.b[i]), .out(sub_b[i]));
  end

  always_comb begin
    // byte 4*c+r is row r of column c, row r rotates left by r
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        shift.b[4*c + r] = sub_b[4*((c + r) % 4) + r];
      end
    end
    for (int c = 0; c < 4; c++) begin
      mix.w[c] = last ? shift.w[c] : mix_col(shift.w[c]);
    end
    next_state = mix ^ round_key;  // AddRoundKey
  end

endmodule

// File: rtl/aes_sbox.sv
// ========================================================================
// aes_sbox
// forward AES substitution box, one byte lane, pure lookup
// ========================================================================

module aes_sbox
  import aes_pkg::*;
(
  input  byte_t in,
  output byte_t out
);

  // table entry 0 sits in the top byte, one row per high nibble
  localparam logic [0:255][7:0] SBOX = {
    128'h637c777bf26b6fc53001672bfed7ab76,  // 0x
    128'hca82c97dfa5947f0add4a2af9ca472c0,  // 1x
    128'hb7fd9326363ff7cc34a5e5f171d83115,  // 2x
    128'h04c723c31896059a071280e2eb27b275,  // 3x
    128'h09832c1a1b6e5aa0523bd6b329e32f84,  // 4x
    128'h53d100ed20fcb15b6acbbe394a4c58cf,  // 5x
    128'hd0efaafb434d338545f9027f503c9fa8,  // 6x
    128'h51a3408f929d38f5bcb6da2110fff3d2,  // 7x
    128'hcd0c13ec5f974417c4a77e3d645d1973,  // 8x
    128'h60814fdc222a908846eeb814de5e0bdb,  // 9x
    128'he0323a0a4906245cc2d3ac629195e479,  // ax
    128'he7c8376d8dd54ea96c56f4ea657aae08,  // bx
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,  // cx
    128'h703eb5664803f60e613557b986c11d9e,  // dx
    128'he1f8981169d98e949b1e87e9ce5528df,  // ex
    128'h8ca1890dbfe6426841992d0fb054bb16   // fx
  };

  assign out = SBOX[in];  // maps to a rom or luts

endmodule

// File: rtl/aes_soc_top.sv
// ========================================================================
// aes_soc_top
// AES-128 accelerator on wishbone plus the cold, warm and debug
// reset request pulse generators
// ========================================================================

module aes_soc_top
  import aes_pkg::*;
#(
  parameter int COLD_PULSE  = 6,
  parameter int WARM_PULSE  = 2,
  parameter int DEBUG_PULSE = 32
) (
  input  logic       clock_50,
  input  logic       rst_n,
  input  logic       wb_cyc,
  input  logic       wb_stb,
  input  logic       wb_we,
  input  reg_addr_t  wb_adr,
  input  word_t      wb_dat_w,
  output word_t      wb_dat_r,
  output logic       wb_ack,
  input  logic [2:0] reset_req,    // 0 cold, 1 warm, 2 debug
  output logic       cold_reset,
  output logic       warm_reset,
  output logic       debug_reset
);

  logic       start;
  logic       busy;
  logic       done;
  aes_block_u plaintext;
  aes_block_u key;
  aes_block_u ciphertext;

  wb_aes_regs regs_i (
    .clock_50, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
    .wb_dat_r, .wb_ack, .start, .plaintext, .key, .busy, .done, .ciphertext
  );

  aes_core core_i (
    .clock_50, .rst_n, .start, .plaintext, .key, .busy, .done, .ciphertext
  );

  // ======================================================================
  // reset request pulses
  // ======================================================================
  reset_pulse_ext #(.PULSE_EXT(COLD_PULSE)) pulse_cold_reset (
    .clock_50, .rst_n, .signal_in(reset_req[0]), .pulse_out(cold_reset)
  );

  reset_pulse_ext #(.PULSE_EXT(WARM_PULSE)) pulse_warm_reset (
    .clock_50, .rst_n, .signal_in(reset_req[1]), .pulse_out(warm_reset)
  );

  reset_pulse_ext #(.PULSE_EXT(DEBUG_PULSE)) pulse_debug_reset (
    .clock_50, .rst_n, .signal_in(reset_req[2]), .pulse_out(debug_reset)
  );

endmodule

// File: rtl/reset_pulse_ext.sv
// ========================================================================
// reset_pulse_ext
// rising edge of a reset request gives a pulse of PULSE_EXT cycles
// ========================================================================

module reset_pulse_ext #(
  parameter int PULSE_EXT = 6  // pulse length in cycles
) (
  input  logic clock_50,
  input  logic rst_n,
  input  logic signal_in,
  output logic pulse_out
);

  localparam int CNT_W = $clog2(PULSE_EXT + 1);

  logic             signal_q;   // first stage
  logic             signal_qq;  // previous value, for edge detect
  logic [CNT_W-1:0] count;      // cycles of pulse left

  always_ff @(posedge clock_50) begin
    if (!rst_n) begin
      signal_q  <= 1'b0;
      signal_qq <= 1'b0;
      count     <= '0;
    end else begin
      signal_q  <= signal_in;
      signal_qq <= signal_q;
      if (count != '0) count <= count - 1'b1;            // edges ignored here
      else if (signal_q && !signal_qq) count <= CNT_W'(PULSE_EXT);
    end
  end

  assign pulse_out = (count != '0);

endmodule

// File: rtl/wb_aes_regs.sv
// ========================================================================
// wb_aes_regs
// wishbone classic slave holding plaintext, key, ciphertext, control
// and status of the AES core
// ========================================================================

module wb_aes_regs
  import aes_pkg::*;
(
  input  logic       clock_50,
  input  logic       rst_n,
  input  logic       wb_cyc,
  input  logic       wb_stb,
  input  logic       wb_we,
  input  reg_addr_t  wb_adr,
  input  word_t      wb_dat_w,
  output word_t      wb_dat_r,
  output logic       wb_ack,
  output logic       start,       // one cycle command to the core
  output aes_block_u plaintext,
  output aes_block_u key,
  input  logic       busy,
  input  logic       done,
  input  aes_block_u ciphertext
);

  logic       wb_req;     // new access this cycle
  logic       done_flag;  // sticky until next start
  aes_block_u ct_q;       // captured ciphertext

  assign wb_req = wb_cyc && wb_stb && !wb_ack;

  // ======================================================================
  // writes, ack and capture
  // ======================================================================
  always_ff @(posedge clock_50) begin
    if (!rst_n) begin
      wb_ack    <= 1'b0;
      start     <= 1'b0;
      plaintext <= '0;
      key       <= '0;
      ct_q      <= '0;
      done_flag <= 1'b0;
    end else begin
      wb_ack <= wb_req;  // single cycle ack, no wait states
      start  <= 1'b0;
      if (wb_req && wb_we) begin
        case (wb_adr)
          REG_CTRL: begin
            start <= wb_dat_w[0];
            if (wb_dat_w[0]) done_flag <= 1'b0;
          end
          REG_PT0:  plaintext.w[0] <= wb_dat_w;
          REG_PT1:  plaintext.w[1] <= wb_dat_w;
          REG_PT2:  plaintext.w[2] <= wb_dat_w;
          REG_PT3:  plaintext.w[3] <= wb_dat_w;
          REG_KEY0: key.w[0] <= wb_dat_w;
          REG_KEY1: key.w[1] <= wb_dat_w;
          REG_KEY2: key.w[2] <= wb_dat_w;
          REG_KEY3: key.w[3] <= wb_dat_w;
          default:  ;  // ct and status are read only
        endcase
      end
      if (done) begin
        ct_q      <= ciphertext;
        done_flag <= 1'b1;  // wins over a clear in the same cycle
      end
    end
  end

  // read data, registered with the ack
  always_ff @(posedge clock_50) begin
    if (!rst_n) begin
      wb_dat_r <= '0;
    end else if (wb_req && !wb_we) begin
      case (wb_adr)
        REG_PT0:    wb_dat_r <= plaintext.w[0];
        REG_PT1:    wb_dat_r <= plaintext.w[1];
        REG_PT2:    wb_dat_r <= plaintext.w[2];
        REG_PT3:    wb_dat_r <= plaintext.w[3];
        REG_KEY0:   wb_dat_r <= key.w[0];
        REG_KEY1:   wb_dat_r <= key.w[1];
        REG_KEY2:   wb_dat_r <= key.w[2];
        REG_KEY3:   wb_dat_r <= key.w[3];
        REG_CT0:    wb_dat_r <= ct_q.w[0];
        REG_CT1:    wb_dat_r <= ct_q.w[1];
        REG_CT2:    wb_dat_r <= ct_q.w[2];
        REG_CT3:    wb_dat_r <= ct_q.w[3];
        REG_STATUS: wb_dat_r <= {30'd0, done_flag, busy};
        default:    wb_dat_r <= '0;  // ctrl and unmapped
      endcase
    end
  end

endmodule

// File: verif/tb_aes_soc.sv
// ==========================================================================
// tb_aes_soc
// testbench for the wishbone AES-128 accelerator and the reset pulses
// ==========================================================================

module tb_aes_soc
  import aes_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int WATCHDOG_NS = 20000;         // ~500 cycles of stimulus, x4 margin
  localparam int PULSE_LEN [3] = '{6, 2, 32};  // cold, warm, debug
  localparam aes_block_u KEY_A = 128'h000102030405060708090a0b0c0d0e0f;
  localparam aes_block_u PT_A  = 128'h00112233445566778899aabbccddeeff;
  localparam aes_block_u CT_A  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
  localparam aes_block_u KEY_B = 128'h2b7e151628aed2a6abf7158809cf4f3c;
  localparam aes_block_u PT_B  = 128'h3243f6a8885a308d313198a2e0370734;
  localparam aes_block_u CT_B  = 128'h3925841d02dc09fbdc118597196a0b32;

  logic       clock_50;
  logic       rst_n;
  logic       wb_cyc;
  logic       wb_stb;
  logic       wb_we;
  reg_addr_t  wb_adr;
  word_t      wb_dat_w;
  word_t      wb_dat_r;
  logic       wb_ack;
  logic [2:0] reset_req;
  logic       cold_reset;
  logic       warm_reset;
  logic       debug_reset;

  integer seed = 12408;
  int     cycle = 0;                   // rising edges so far
  int     ack_cycle;                   // edge of the latest ack
  int     run_len [3]  = '{default: 0};
  int     last_len [3] = '{default: 0};  // width of the last finished pulse
  int     pulses [3]   = '{default: 0};

  aes_soc_top aes_soc_top_i (
    .clock_50, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
    .wb_dat_r, .wb_ack, .reset_req, .cold_reset, .warm_reset, .debug_reset
  );

  initial begin
    clock_50 = 1'b0;
    forever #5 clock_50 = ~clock_50;  // 100 MHz sim clock
  end

  always @(posedge clock_50) cycle <= cycle + 1;

  initial begin
    #(WATCHDOG_NS);
    fail_now("watchdog expired, stimulus did not complete");
  end

  // ==========================================================================
  // checkers
  // ==========================================================================
  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    assert (act === exp)
      else fail_now($sformatf("ERR t=%0t %s expected %08h actual %08h",
                              $time, name, exp, act));
  endtask

  ack_after_req: assert property (@(posedge clock_50) disable iff (!rst_n)
    (wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
    else fail_now("wb_ack did not rise one cycle after a request");

  ack_single: assert property (@(posedge clock_50) disable iff (!rst_n)
    wb_ack |=> !wb_ack)
    else fail_now("wb_ack stayed high for two cycles");

  // pulse widths, sampled mid cycle away from the edges
  always @(negedge clock_50) begin
    logic [2:0] outs;
    outs = {debug_reset, warm_reset, cold_reset};
    for (int i = 0; i < 3; i++) begin
      if (outs[i]) run_len[i]++;
      else if (run_len[i] != 0) begin  // falling edge, pulse complete
        last_len[i] = run_len[i];
        pulses[i]++;
        run_len[i] = 0;
      end
    end
  end

  task automatic expect_pulses(input int n);
    for (int i = 0; i < 3; i++) begin
      check_word($sformatf("pulse count %0d", i), n, pulses[i]);
      check_word($sformatf("pulse width %0d", i), PULSE_LEN[i], last_len[i]);
    end
  endtask

  // ==========================================================================
  // bus tasks, inputs change 1 ns after the edge
  // ==========================================================================
  task automatic tick(input int n = 1);
    repeat (n) begin
      @(posedge clock_50);
      #1;
    end
  endtask

  task automatic wb_access(input logic we, input reg_addr_t adr, input word_t dat,
                           output word_t rdata);
    int waits;
    waits    = 0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = dat;
    do begin
      tick();
      waits++;
    end while (!wb_ack && waits < 4);  // back to back needs 2
    assert (wb_ack) else fail_now("no wishbone ack within 4 cycles");
    rdata     = wb_dat_r;
    ack_cycle = cycle;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
  endtask

  task automatic wb_write(input reg_addr_t adr, input word_t dat);
    word_t unused;
    wb_access(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input reg_addr_t adr, output word_t dat);
    wb_access(1'b0, adr, 32'h0, dat);
  endtask

  task automatic check_read(input reg_addr_t adr, input word_t exp, input string name);
    word_t rd;
    wb_read(adr, rd);
    check_word(name, exp, rd);
  endtask

  task automatic load_block(input aes_block_u key, input aes_block_u pt);
    for (int i = 0; i < 4; i++) begin
      wb_write(reg_addr_t'(REG_KEY0 + i), key.w[i]);
      wb_write(reg_addr_t'(REG_PT0 + i), pt.w[i]);
    end
  endtask

  task automatic wait_done();
    word_t st;
    int    polls;
    polls = 0;
    do begin
      wb_read(REG_STATUS, st);
      polls++;
    end while (!st[1] && polls < 40);
    assert (st[1]) else fail_now("done flag not set after 40 status polls");
  endtask

  task automatic check_ct(input aes_block_u ct);
    for (int i = 0; i < 4; i++) begin
      check_read(reg_addr_t'(REG_CT0 + i), ct.w[i], $sformatf("ct%0d", i));
    end
  endtask

  task automatic toggle_req(input int idx, input int n);
    reset_req[idx] = 1'b1;
    tick(n);
    reset_req[idx] = 1'b0;
  endtask

  // ==========================================================================
  // stimulus
  // ==========================================================================
  initial begin
    word_t wr;
    word_t st;
    int    start_ack;
    rst_n     = 1'b0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_w  = '0;
    reset_req = 3'b000;
    repeat (4) @(posedge clock_50);
    #1;
    rst_n = 1'b1;
    tick();

    check_read(REG_STATUS, 32'h0, "status");  // idle, no done flag
    check_ct('0);
    assert ({debug_reset, warm_reset, cold_reset} == 3'b000
            && pulses[0] + pulses[1] + pulses[2] == 0)
      else fail_now("reset pulse output active after reset");

    for (int i = 0; i < 8; i++) begin  // pt0..pt3 then key0..key3
      wr = $random(seed);
      wb_write(reg_addr_t'(REG_PT0 + i), wr);
      check_read(reg_addr_t'(REG_PT0 + i), wr, $sformatf("reg%0d", REG_PT0 + i));
    end
    wr = $random(seed);
    wb_write(REG_CT0, wr);      // read only
    check_read(REG_CT0, 32'h0, "ct0");
    wb_write(REG_STATUS, wr);
    check_read(REG_STATUS, 32'h0, "status");
    check_read(4'd14, 32'h0, "unmapped 14");
    check_read(4'd15, 32'h0, "unmapped 15");

    // known answer vectors
    load_block(KEY_A, PT_A);
    wb_write(REG_CTRL, 32'h1);
    wait_done();
    check_ct(CT_A);
    load_block(KEY_B, PT_B);
    wb_write(REG_CTRL, 32'h1);
    wait_done();
    check_ct(CT_B);

    // core takes start at +1, busy on edges +2..+11, flag readable from +13
    wb_write(REG_CTRL, 32'h1);
    start_ack = ack_cycle;
    for (int i = 0; i < 8; i++) begin
      wb_read(REG_STATUS, st);
      check_word($sformatf("status at +%0d", ack_cycle - start_ack),
                 {30'd0, ack_cycle - start_ack >= 13,
                  ack_cycle - start_ack >= 2 && ack_cycle - start_ack <= 11}, st);
    end
    check_ct(CT_B);

    // second start lands while busy with fresh plaintext
    load_block(KEY_A, PT_A);
    wb_write(REG_CTRL, 32'h1);
    wb_read(REG_STATUS, st);
    assert (st[0]) else fail_now("core not busy right after start");
    wb_write(REG_PT0, $random(seed));
    wb_write(REG_PT1, $random(seed));
    wb_write(REG_CTRL, 32'h1);
    wait_done();
    check_ct(CT_A);

    reset_req = 3'b111;  // held past the longest pulse
    tick(40);
    reset_req = 3'b000;
    tick(3);
    expect_pulses(1);
    toggle_req(0, 1);    // cold, second edge inside its pulse
    tick(1);
    toggle_req(0, 1);
    toggle_req(2, 2);    // debug, same
    tick(4);
    toggle_req(2, 2);
    toggle_req(1, 1);    // warm, one fresh edge
    tick(40);
    expect_pulses(2);

    $display("test passed");
    $finish;
  end

endmodule
